// ==== run.sh ====
#!/bin/bash
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns -f vlog.f \
	--top-module hazardUnitTb -o simv \
	&& ./obj_dir/simv | tee sim.log \
	&& grep -q "TEST RESULT: PASS" sim.log \
	|| { echo "Simulation did not pass"; exit 1; }

// ==== testbench/tbModel.svh ====
`ifndef tbModelSvh
`define tbModelSvh

// Stage record straight from the MIPS encoding
function automatic stageRecT decodeRef(input instrT w);
	stageRecT r;
	logic calcFn;
	calcFn = (w[5:0] inside {6'h21, 6'h23, 6'h24, 6'h25, 6'h2a});
	r = '{kind: kindBubble, rs: w[25:21], rt: w[20:16], dest: 5'd0, result: resNone};
	case (w[31:26])
		6'h00: r.kind = calcFn ? kindCalcR : (w[5:1] == 5'b00100) ? kindJumpReg : kindBubble;
		6'h09, 6'h0a, 6'h0d, 6'h0f: r.kind = kindCalcI;
		6'h23: r.kind = kindLoad;
		6'h2b: r.kind = kindStore;
		6'h04, 6'h05: r.kind = kindBranchTwo;
		6'h06, 6'h07: r.kind = kindBranchOne;
		6'h02, 6'h03: r.kind = kindJump;
		default: r.kind = kindBubble;
	endcase
	if (w[31:26] == 6'h0f)
		r.rs = 5'd0; // lui reads nothing
	if (r.kind inside {kindCalcI, kindLoad})
		r.dest = r.rt;
	else if (r.kind == kindCalcR || (r.kind == kindJumpReg && w[0]))
		r.dest = w[15:11];
	else if (w[31:26] == 6'h03)
		r.dest = 5'd31;
	if (r.dest != 5'd0)
		r.result = (r.kind == kindLoad) ? resMem
			: (r.kind inside {kindJump, kindJumpReg}) ? resLink : resAlu;
	return (r.kind == kindBubble) ? bubbleRec : r;
endfunction

// A from of 0 sees E, M and W, 1 sees M and W and 2 sees W only
function automatic fwdSrcE pickRef(input regIdxT src, input logic used, input int from,
	input stageRecT e, input stageRecT m, input stageRecT w);
	if (!used || src == 5'd0)
		return fwdNormal;
	if (from == 0 && e.dest == src && e.result == resLink)
		return fwdFromEPc;
	if (from <= 1 && m.dest == src && m.result == resLink)
		return fwdFromMPc;
	if (w.dest == src && w.result == resLink)
		return fwdFromWPc;
	if (from <= 1 && m.dest == src && m.result == resAlu)
		return fwdFromM;
	if (w.dest == src && w.result == resAlu)
		return fwdFromWAlu;
	if (w.dest == src && w.result == resMem)
		return fwdFromWMem;
	return fwdNormal;
endfunction

function automatic fwdSelT forwardRef(input stageRecT d, input stageRecT e,
	input stageRecT m, input stageRecT w);
	fwdSelT s;
	s.pcR = pickRef(d.rs, d.kind == kindJumpReg, 0, e, m, w);
	s.cmpA = pickRef(d.rs, d.kind inside {kindBranchOne, kindBranchTwo}, 0, e, m, w);
	s.cmpB = pickRef(d.rt, d.kind == kindBranchTwo, 0, e, m, w);
	s.aluA = pickRef(e.rs, e.kind inside {kindCalcR, kindCalcI, kindLoad, kindStore}, 1, e, m, w);
	s.aluB = pickRef(e.rt, e.kind == kindCalcR, 1, e, m, w);
	s.storeE = pickRef(e.rt, e.kind == kindStore, 2, e, m, w);
	s.storeM = pickRef(m.rt, m.kind == kindStore, 2, e, m, w);
	return s;
endfunction

// Control bits in order pcWr weD weE weM clearD clearE clearM
function automatic pipeCtlT controlRef(input stageRecT d, input stageRecT e, input stageRecT m,
	input logic taken, input logic irq, output logic exc);
	logic dRs;
	logic dRt;
	logic loadUse;
	logic brHaz;
	dRs = d.kind inside {kindBranchOne, kindBranchTwo, kindJumpReg};
	dRt = d.kind == kindBranchTwo;
	loadUse = m.result == resMem && ((e.rs == m.dest
		&& e.kind inside {kindCalcR, kindCalcI, kindLoad, kindStore})
		|| (e.kind == kindCalcR && e.rt == m.dest));
	brHaz = (e.result inside {resAlu, resMem}
		&& ((dRs && d.rs == e.dest) || (dRt && d.rt == e.dest)))
		|| (m.result == resMem && ((dRs && d.rs == m.dest) || (dRt && d.rt == m.dest)));
	exc = 1'b0;
	if (loadUse)
		return 7'b0000001;
	if (brHaz)
		return 7'b0001010;
	if (d.kind inside {kindJump, kindJumpReg}
		|| (taken && d.kind inside {kindBranchOne, kindBranchTwo}))
		return 7'b1111000;
	exc = irq;
	return irq ? 7'b1011100 : 7'b1111000;
endfunction

`endif

// ==== testbench/hazardUnitTb.sv ====
`timescale 1ns/1ns

module hazardUnitTb import hazardPkg::*; ();

`include "tbModel.svh"

	logic clk;
	logic rstN;
	instrT instrF;
	logic branchOk;
	logic intReq;
	fwdSelT fwdSel;
	pipeCtlT pipeCtl;
	logic excEnter;
	stageRecT mD; // Model stage records
	stageRecT mE;
	stageRecT mM;
	stageRecT mW;
	fwdSelT expFwd;
	pipeCtlT expCtl;
	logic expExc;
	string testName;
	int errors;
	int testCount;
	int testStartErrors;

	hazardUnit dut (.*);

	always #10 clk = ~clk;

	always_comb
	begin
		expFwd = forwardRef(mD, mE, mM, mW);
		expCtl = controlRef(mD, mE, mM, branchOk, intReq, expExc);
	end

	// Model advances on its own controls
	always @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			mD <= bubbleRec;
			mE <= bubbleRec;
			mM <= bubbleRec;
			mW <= bubbleRec;
		end
		else
		begin
			if (expCtl.clearD)
				mD <= bubbleRec;
			else if (expCtl.weD)
				mD <= decodeRef(instrF);
			if (expCtl.clearE)
				mE <= bubbleRec;
			else if (expCtl.weE)
				mE <= mD;
			if (expCtl.clearM)
				mM <= bubbleRec;
			else if (expCtl.weM)
				mM <= mE;
			mW <= mM;
		end
	end

	task automatic mismatch(input string what, input logic [20:0] exp, input logic [20:0] act);
		errors++;
		$display("CHECK FAILED %s %s expected %h actual %h", testName, what, exp, act);
	endtask

	fwdCheck: assert property (@(negedge clk) disable iff (!rstN) fwdSel == expFwd)
		else mismatch("fwdSel", expFwd, fwdSel);
	ctlCheck: assert property (@(negedge clk) disable iff (!rstN) pipeCtl == expCtl)
		else mismatch("pipeCtl", {14'd0, expCtl}, {14'd0, pipeCtl});
	excCheck: assert property (@(negedge clk) disable iff (!rstN) excEnter == expExc)
		else mismatch("excEnter", {20'd0, expExc}, {20'd0, excEnter});

	function automatic instrT encR(input regIdxT rs, input regIdxT rt, input regIdxT rd,
		input functE fn);
		return {opSpecial, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic instrT encI(input opcodeE op, input regIdxT rs, input regIdxT rt);
		return {op, rs, rt, 16'h0004};
	endfunction

	// Registers 0..3 only, so hazards come often
	function automatic instrT randomInstr();
		logic [31:0] k;
		regIdxT a;
		regIdxT b;
		regIdxT c;
		k = $urandom;
		a = {3'd0, k[11:10]};
		b = {3'd0, k[13:12]};
		c = {3'd0, k[15:14]};
		case (k[3:0])
			4'd0: return encR(a, b, c, fnAddu);
			4'd1: return encR(a, b, c, fnSubu);
			4'd2: return encR(a, b, c, fnAnd);
			4'd3: return encR(a, b, c, fnOr);
			4'd4: return encR(a, b, c, fnSlt);
			4'd5: return encI(opAddiu, a, b);
			4'd6: return encI(k[4] ? opOri : opSlti, a, b);
			4'd7: return encI(opLui, 5'd0, b);
			4'd8, 4'd9: return encI(opLw, a, b);
			4'd10: return encI(opSw, a, b);
			4'd11: return encI(k[4] ? opBeq : opBne, a, b);
			4'd12: return encI(k[4] ? opBlez : opBgtz, a, 5'd0);
			4'd13: return encI(k[4] ? opJ : opJal, 5'd0, 5'd0);
			4'd14: return encR(a, 5'd0, c, k[4] ? fnJr : fnJalr);
			default: return k; // Mostly outside the subset
		endcase
	endfunction

	// Present the word until the PC moves past it
	task automatic issue(input instrT w);
		int cycles;
		logic taken;
		instrF = w;
		taken = 1'b0;
		cycles = 0;
		while (!taken && cycles < 20)
		begin
			@(negedge clk);
			taken = pipeCtl.pcWr;
			@(posedge clk);
			#2;
			cycles++;
		end
		if (!taken)
		begin
			$display("Timeout in %s: word %h still stalled after %0d cycles", testName, w, cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) issue('0);
	endtask

	task automatic randomFiller(input int n);
		logic [31:0] k;
		repeat (n)
		begin
			k = $urandom;
			branchOk = k[0];
			intReq = (k[3:1] == 3'd0);
			issue(randomInstr());
		end
		branchOk = 1'b0;
		intReq = 1'b0;
		idle(4);
	endtask

	task automatic reportTest();
		$display("%s: %0d failures", testName, errors - testStartErrors);
		testStartErrors = errors;
		testCount++;
	endtask

	initial
	begin
		void'($urandom(32'h8f6));
		clk = 1'b0;
		rstN = 1'b0;
		instrF = '0;
		branchOk = 1'b0;
		intReq = 1'b0;
		errors = 0;
		testCount = 0;
		testStartErrors = 0;
		testName = "reset";
		repeat (5) @(posedge clk);
		#2;
		rstN = 1'b1;
		idle(4);
		reportTest();

		testName = "forwarding";
		issue(encR(5'd2, 5'd3, 5'd1, fnAddu));
		issue(encR(5'd1, 5'd1, 5'd4, fnAddu)); // fromM on both ALU inputs
		issue(encI(opSw, 5'd4, 5'd1)); // store data from W ALU
		issue(encR(5'd1, 5'd1, 5'd0, fnAddu));
		issue(encR(5'd0, 5'd0, 5'd5, fnAddu)); // $0 must stay normal
		issue(encI(opJal, 5'd0, 5'd0));
		issue(encR(5'd31, 5'd0, 5'd0, fnJr)); // link from E
		issue(encI(opBeq, 5'd31, 5'd1)); // link from M
		issue(encI(opBne, 5'd31, 5'd0)); // link from W
		issue(encI(opLw, 5'd1, 5'd6));
		idle(1);
		issue(encI(opSw, 5'd2, 5'd6)); // store data from W load
		idle(4);
		randomFiller(20);
		reportTest();

		testName = "loadUse";
		issue(encI(opLw, 5'd1, 5'd7));
		issue(encR(5'd7, 5'd7, 5'd8, fnAddu));
		issue(encR(5'd8, 5'd7, 5'd9, fnAddu));
		idle(4);
		randomFiller(20);
		reportTest();

		testName = "branchHazard";
		issue(encR(5'd1, 5'd2, 5'd10, fnAddu));
		issue(encI(opBeq, 5'd10, 5'd0)); // ALU result in E
		issue(encI(opLw, 5'd1, 5'd11));
		issue(encR(5'd11, 5'd0, 5'd0, fnJr)); // load in E, then in M
		issue(encI(opLw, 5'd1, 5'd12));
		issue('0);
		issue(encI(opBgtz, 5'd12, 5'd0)); // load in M
		idle(4);
		randomFiller(20);
		reportTest();

		testName = "jumpInterrupt";
		issue(encI(opJ, 5'd0, 5'd0));
		intReq = 1'b1;
		issue('0); // jump in D takes precedence
		intReq = 1'b0;
		issue(encI(opBeq, 5'd0, 5'd0));
		branchOk = 1'b1;
		intReq = 1'b1;
		issue('0); // taken branch in D
		branchOk = 1'b0;
		intReq = 1'b0;
		issue(encR(5'd1, 5'd2, 5'd3, fnAddu));
		intReq = 1'b1;
		issue('0); // plain addu in D, interrupt entry
		intReq = 1'b0;
		idle(4);
		randomFiller(20);
		reportTest();

		testName = "randomMix";
		randomFiller(400);
		reportTest();

		$display("%0d tests, %0d failures", testCount, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== verilog/forwardSelect.sv ====
`timescale 1ns/1ns

module forwardSelect import hazardPkg::*; (
	input stageRecT recD,
	input stageRecT recE,
	input stageRecT recM,
	input stageRecT recW,
	output fwdSelT fwdSel
);

	logic dJumpReg;
	logic dBranch;
	logic dBranchTwo;
	logic eReadsRs;
	logic eCalcR;
	logic eStore;
	logic mStore;

	function automatic logic provides(
		input stageRecT prov,
		input regIdxT src,
		input resultE res
	);
		return (prov.dest == src) && (prov.result == res);
	endfunction

	// First matching provider, link results ahead of data results
	function automatic fwdSrcE pickSrc(
		input regIdxT src,
		input logic used,
		input logic seeE,
		input logic seeM,
		input stageRecT provE,
		input stageRecT provM,
		input stageRecT provW
	);
		fwdSrcE sel;
		sel = fwdNormal;
		if (used && (src != zeroReg))
		begin
			if (seeE && provides(provE, src, resLink))
				sel = fwdFromEPc;
			else if (seeM && provides(provM, src, resLink))
				sel = fwdFromMPc;
			else if (provides(provW, src, resLink))
				sel = fwdFromWPc;
			else if (seeM && provides(provM, src, resAlu))
				sel = fwdFromM;
			else if (provides(provW, src, resAlu))
				sel = fwdFromWAlu;
			else if (provides(provW, src, resMem))
				sel = fwdFromWMem;
		end
		return sel;
	endfunction

	assign dJumpReg = (recD.kind == kindJumpReg);
	assign dBranchTwo = (recD.kind == kindBranchTwo);
	assign dBranch = dBranchTwo || (recD.kind == kindBranchOne);
	assign eCalcR = (recE.kind == kindCalcR);
	assign eStore = (recE.kind == kindStore);
	assign eReadsRs = eCalcR || eStore || (recE.kind == kindCalcI) || (recE.kind == kindLoad);
	assign mStore = (recM.kind == kindStore);

	always_comb
	begin
		// D-stage consumers see every later stage
		fwdSel.pcR = pickSrc(recD.rs, dJumpReg, 1'b1, 1'b1, recE, recM, recW);
		fwdSel.cmpA = pickSrc(recD.rs, dBranch, 1'b1, 1'b1, recE, recM, recW);
		fwdSel.cmpB = pickSrc(recD.rt, dBranchTwo, 1'b1, 1'b1, recE, recM, recW);

		fwdSel.aluA = pickSrc(recE.rs, eReadsRs, 1'b0, 1'b1, recE, recM, recW);
		fwdSel.aluB = pickSrc(recE.rt, eCalcR, 1'b0, 1'b1, recE, recM, recW);

		// Store data only from W
		fwdSel.storeE = pickSrc(recE.rt, eStore, 1'b0, 1'b0, recE, recM, recW);
		fwdSel.storeM = pickSrc(recM.rt, mStore, 1'b0, 1'b0, recE, recM, recW);
	end

endmodule

// ==== verilog/hazardPkg.sv ====
package hazardPkg;

	localparam int opcodeMsb = 31;
	localparam int opcodeLsb = 26;
	localparam int rsMsb = 25;
	localparam int rsLsb = 21;
	localparam int rtMsb = 20;
	localparam int rtLsb = 16;
	localparam int rdMsb = 15;
	localparam int rdLsb = 11;
	localparam int functMsb = 5;
	localparam int functLsb = 0;

	typedef logic [4:0] regIdxT;
	typedef logic [31:0] instrT;

	localparam regIdxT linkReg = 5'd31; // jal target
	localparam regIdxT zeroReg = 5'd0;

	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opJ = 6'h02,
		opJal = 6'h03,
		opBeq = 6'h04,
		opBne = 6'h05,
		opBlez = 6'h06,
		opBgtz = 6'h07,
		opAddiu = 6'h09,
		opSlti = 6'h0a,
		opOri = 6'h0d,
		opLui = 6'h0f,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcodeE;

	typedef enum logic [5:0] {
		fnJr = 6'h08,
		fnJalr = 6'h09,
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd = 6'h24,
		fnOr = 6'h25,
		fnSlt = 6'h2a
	} functE;

	typedef enum logic [3:0] {
		kindBubble,
		kindCalcR,
		kindCalcI,
		kindLoad,
		kindStore,
		kindBranchTwo, // beq, bne
		kindBranchOne, // blez, bgtz
		kindJump,
		kindJumpReg
	} opKindE;

	typedef enum logic [1:0] {
		resNone,
		resAlu,
		resMem,
		resLink // PC+8 written back
	} resultE;

	typedef struct packed {
		opKindE kind;
		regIdxT rs;
		regIdxT rt;
		regIdxT dest;
		resultE result;
	} stageRecT;

	localparam stageRecT bubbleRec = '{
		kind: kindBubble,
		rs: zeroReg,
		rt: zeroReg,
		dest: zeroReg,
		result: resNone
	};

	typedef enum logic [2:0] {
		fwdNormal,
		fwdFromEPc,
		fwdFromMPc,
		fwdFromWPc,
		fwdFromM,
		fwdFromWAlu,
		fwdFromWMem
	} fwdSrcE;

	typedef struct packed {
		fwdSrcE pcR;
		fwdSrcE cmpA;
		fwdSrcE cmpB;
		fwdSrcE aluA;
		fwdSrcE aluB;
		fwdSrcE storeE;
		fwdSrcE storeM;
	} fwdSelT;

	typedef struct packed {
		logic pcWr;
		logic weD;
		logic weE;
		logic weM;
		logic clearD;
		logic clearE;
		logic clearM;
	} pipeCtlT;

endpackage

// ==== verilog/hazardUnit.sv ====
`timescale 1ns/1ns

module hazardUnit import hazardPkg::*; (
	input logic clk,
	input logic rstN,
	input instrT instrF,
	input logic branchOk,
	input logic intReq,
	output fwdSelT fwdSel,
	output pipeCtlT pipeCtl,
	output logic excEnter
);

	stageRecT recF;
	stageRecT recD;
	stageRecT recE;
	stageRecT recM;
	stageRecT recW;

	instrDecoder decoder (
		.instr(instrF),
		.rec(recF)
	);

	stagePipe pipe (
		.clk(clk),
		.rstN(rstN),
		.recF(recF),
		.pipeCtl(pipeCtl),
		.recD(recD),
		.recE(recE),
		.recM(recM),
		.recW(recW)
	);

	forwardSelect forward (
		.recD(recD),
		.recE(recE),
		.recM(recM),
		.recW(recW),
		.fwdSel(fwdSel)
	);

	stallControl stall (
		.recD(recD),
		.recE(recE),
		.recM(recM),
		.branchOk(branchOk),
		.intReq(intReq),
		.pipeCtl(pipeCtl),
		.excEnter(excEnter)
	);

endmodule

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/1ns

module instrDecoder import hazardPkg::*; (
	input instrT instr,
	output stageRecT rec
);

	logic [5:0] opcode;
	logic [5:0] funct;
	regIdxT rs;
	regIdxT rt;
	regIdxT rd;
	opKindE kind;
	regIdxT dest;
	resultE result;
	logic isJal;
	logic isJalr;

	assign opcode = instr[opcodeMsb:opcodeLsb];
	assign funct = instr[functMsb:functLsb];
	assign rt = instr[rtMsb:rtLsb];
	assign rd = instr[rdMsb:rdLsb];
	assign rs = (opcode == opLui) ? zeroReg : instr[rsMsb:rsLsb]; // lui has no source

	always_comb
	begin
		kind = kindBubble;
		case (opcode)
			opSpecial:
				case (funct)
					fnAddu, fnSubu, fnAnd, fnOr, fnSlt:
						kind = kindCalcR;
					fnJr, fnJalr:
						kind = kindJumpReg;
					default:
						kind = kindBubble;
				endcase
			opAddiu, opSlti, opOri, opLui:
				kind = kindCalcI;
			opLw:
				kind = kindLoad;
			opSw:
				kind = kindStore;
			opBeq, opBne:
				kind = kindBranchTwo;
			opBlez, opBgtz:
				kind = kindBranchOne;
			opJ, opJal:
				kind = kindJump;
			default:
				kind = kindBubble; // Outside the subset
		endcase
	end

	assign isJal = (kind == kindJump) && (opcode == opJal);
	assign isJalr = (kind == kindJumpReg) && (funct == fnJalr);

	always_comb
	begin
		case (kind)
			kindCalcR:
				dest = rd;
			kindCalcI, kindLoad:
				dest = rt;
			kindJump:
				dest = isJal ? linkReg : zeroReg;
			kindJumpReg:
				dest = isJalr ? rd : zeroReg;
			default:
				dest = zeroReg;
		endcase

		if (dest == zeroReg)
			result = resNone; // $0 never written
		else if (kind == kindLoad)
			result = resMem;
		else if (isJal || isJalr)
			result = resLink;
		else
			result = resAlu;
	end

	assign rec = (kind == kindBubble) ? bubbleRec :
		'{kind: kind, rs: rs, rt: rt, dest: dest, result: result};

endmodule

// ==== verilog/stagePipe.sv ====
`timescale 1ns/1ns

module stagePipe import hazardPkg::*; (
	input logic clk,
	input logic rstN,
	input stageRecT recF,
	input pipeCtlT pipeCtl,
	output stageRecT recD,
	output stageRecT recE,
	output stageRecT recM,
	output stageRecT recW
);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			recD <= bubbleRec;
			recE <= bubbleRec;
			recM <= bubbleRec;
			recW <= bubbleRec;
		end
		else
		begin
			// Clear beats enable
			if (pipeCtl.clearD)
				recD <= bubbleRec;
			else if (pipeCtl.weD)
				recD <= recF;

			if (pipeCtl.clearE)
				recE <= bubbleRec;
			else if (pipeCtl.weE)
				recE <= recD;

			if (pipeCtl.clearM)
				recM <= bubbleRec;
			else if (pipeCtl.weM)
				recM <= recE;

			recW <= recM; // W never stalls
		end
	end

endmodule

// ==== verilog/stallControl.sv ====
`timescale 1ns/1ns

module stallControl import hazardPkg::*; (
	input stageRecT recD,
	input stageRecT recE,
	input stageRecT recM,
	input logic branchOk,
	input logic intReq,
	output pipeCtlT pipeCtl,
	output logic excEnter
);

	logic dUsesRs;
	logic dUsesRt;
	logic eUsesRs;
	logic eUsesRt;
	logic loadUse;
	logic branchHaz;
	logic redirect;

	// Source waits on a value not yet available for forwarding
	function automatic logic pending(
		input regIdxT src,
		input logic used,
		input stageRecT prov,
		input logic aluToo
	);
		return used && (src != zeroReg) && (src == prov.dest)
			&& ((prov.result == resMem) || (aluToo && (prov.result == resAlu)));
	endfunction

	assign dUsesRs = (recD.kind == kindBranchOne) || (recD.kind == kindBranchTwo)
		|| (recD.kind == kindJumpReg);
	assign dUsesRt = (recD.kind == kindBranchTwo);
	assign eUsesRs = (recE.kind == kindCalcR) || (recE.kind == kindCalcI)
		|| (recE.kind == kindLoad) || (recE.kind == kindStore);
	assign eUsesRt = (recE.kind == kindCalcR); // sw data comes later via storeM

	assign loadUse = pending(recE.rs, eUsesRs, recM, 1'b0) || pending(recE.rt, eUsesRt, recM, 1'b0);
	assign branchHaz = pending(recD.rs, dUsesRs, recE, 1'b1) || pending(recD.rt, dUsesRt, recE, 1'b1)
		|| pending(recD.rs, dUsesRs, recM, 1'b0) || pending(recD.rt, dUsesRt, recM, 1'b0);
	assign redirect = (recD.kind == kindJump) || (recD.kind == kindJumpReg)
		|| (dUsesRs && (recD.kind != kindJumpReg) && branchOk);

	always_comb
	begin
		pipeCtl = '{pcWr: 1'b1, weD: 1'b1, weE: 1'b1, weM: 1'b1,
			clearD: 1'b0, clearE: 1'b0, clearM: 1'b0};
		excEnter = 1'b0;
		if (loadUse)
		begin
			pipeCtl.pcWr = 1'b0; // Freeze F..E, bubble into M
			pipeCtl.weD = 1'b0;
			pipeCtl.weE = 1'b0;
			pipeCtl.weM = 1'b0;
			pipeCtl.clearM = 1'b1;
		end
		else if (branchHaz)
		begin
			pipeCtl.pcWr = 1'b0; // Hold D, bubble into E
			pipeCtl.weD = 1'b0;
			pipeCtl.weE = 1'b0;
			pipeCtl.clearE = 1'b1;
		end
		else if (!redirect && intReq)
		begin
			// Delay slot safe here, so drop the fetched word
			pipeCtl.weD = 1'b0;
			pipeCtl.clearD = 1'b1;
			excEnter = 1'b1;
		end
	end

endmodule

// ==== vlog.f ====
+incdir+testbench
verilog/hazardPkg.sv
verilog/instrDecoder.sv
verilog/stagePipe.sv
verilog/forwardSelect.sv
verilog/stallControl.sv
verilog/hazardUnit.sv
testbench/hazardUnitTb.sv
